// ==== dv/huffTreeTb.sv ====
`timescale 1ns/1ps

module huffTreeTb;
    import huffPkg::*;

    localparam int HalfPeriod  = 20;           // 40 ns clock
    localparam int ResetCycles = 10;
    localparam int RandomRuns  = 20;
    localparam int RunCycles   = 40;           // generous bound for one run
    localparam int MaxCycles   = (RandomRuns + 2) * RunCycles + 20;
    localparam int AckLatency  = 28;           // 1 load + 9 rounds of 3

    logic                        Clk_in = 1'b0;
    logic                        n_Rst;
    logic                        Req;
    logic                        Ack;
    weight_t [NumLeaves-1:0]     LeafWeights;
    treeEntry_t [NumEntries-1:0] TreeTable;
    nodeIdx_t                    RootRight;
    nodeIdx_t                    RootLeft;

    weight_t [NumLeaves-1:0]     runWeights;
    treeEntry_t [NumEntries-1:0] expTable;
    nodeIdx_t                    expRight;
    nodeIdx_t                    expLeft;
    logic [31:0]                 lfsrState = 32'hda72;
    int                          cycleCount = 0;
    int                          reqAge = 0;       // edges with Req seen high
    logic                        seenReq = 1'b0;

    huffTreeTop dut_i
    (
        .Clk_in      (Clk_in),
        .n_Rst       (n_Rst),
        .Req         (Req),
        .Ack         (Ack),
        .LeafWeights (LeafWeights),
        .TreeTable   (TreeTable),
        .RootRight   (RootRight),
        .RootLeft    (RootLeft)
    );

    always #HalfPeriod Clk_in = ~Clk_in;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            val = (val << 1) | int'(lfsrState[0]);
        end
    endtask

    // nine sorted cuts in 0..256 split the total into ten leaves
    task automatic makeRandomWeights();
        int  cuts [NumLeaves-1];
        int  cut;
        int  tmp;
        int  lo;
        int  hi;
        bit  inRange;
        inRange = 1'b0;
        while (!inRange)
        begin
            for (int i = 0; i < NumLeaves - 1; i++)
            begin
                cut = int'(TotalWeight) + 1;
                while (cut > int'(TotalWeight))
                begin
                    takeBits(WeightW, cut);
                end
                cuts[i] = cut;
            end
            for (int i = 1; i < NumLeaves - 1; i++)
            begin
                for (int j = i; j > 0 && cuts[j-1] > cuts[j]; j--)
                begin
                    tmp       = cuts[j];
                    cuts[j]   = cuts[j-1];
                    cuts[j-1] = tmp;
                end
            end
            inRange = 1'b1;
            for (int i = 0; i < NumLeaves; i++)
            begin
                lo = (i == 0) ? 0 : cuts[i-1];
                hi = (i == NumLeaves - 1) ? int'(TotalWeight) : cuts[i];
                if (hi - lo >= int'(TotalWeight))
                begin
                    inRange = 1'b0;          // single leaf holding everything
                end
                runWeights[i] = weight_t'(hi - lo);
            end
        end
    endtask

    // as close to equal as 256 over ten allows
    task automatic makeTiedWeights();
        for (int i = 0; i < NumLeaves; i++)
        begin
            runWeights[i] = (i < 6) ? weight_t'(26) : weight_t'(25);
        end
    endtask

    task automatic makeZeroWeights();
        runWeights    = '0;
        runWeights[3] = weight_t'(64);
        runWeights[8] = weight_t'(192);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic buildReference();
        int wt    [NumNodes];
        bit avail [NumNodes];
        int pick  [2];
        int nextParent;
        int sum;
        for (int i = 0; i < NumNodes; i++)
        begin
            wt[i]    = (i < NumLeaves) ? int'(runWeights[i]) : 0;
            avail[i] = (i < NumLeaves);
        end
        nextParent = NumLeaves;
        expTable   = '0;
        for (int r = 0; r < NumNodes; r++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                pick[k] = -1;
                for (int i = 0; i < NumNodes; i++)
                begin
                    if (avail[i] && (pick[k] < 0 || wt[i] < wt[pick[k]]))
                    begin
                        pick[k] = i;                // first seen wins a tie
                    end
                end
                avail[pick[k]] = 1'b0;
            end
            sum = wt[pick[0]] + wt[pick[1]];
            if (sum >= int'(TotalWeight))
            begin
                expRight = nodeIdx_t'(pick[0]);
                expLeft  = nodeIdx_t'(pick[1]);
                break;
            end
            wt[nextParent]    = sum;
            avail[nextParent] = 1'b1;
            expTable[nextParent - NumLeaves] =
                {nodeIdx_t'(nextParent), nodeIdx_t'(pick[1]), nodeIdx_t'(pick[0])};
            nextParent++;
        end
    endtask

    // one full four-phase handshake
    task automatic runTree();
        int holdCycles;
        int gapCycles;
        buildReference();
        takeBits(1, holdCycles);
        takeBits(1, gapCycles);
        @(posedge Clk_in);
        LeafWeights <= runWeights;
        Req         <= 1'b1;
        do @(posedge Clk_in); while (!Ack);
        repeat (holdCycles) @(posedge Clk_in);
        Req <= 1'b0;
        do @(posedge Clk_in); while (Ack);
        repeat (gapCycles) @(posedge Clk_in);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge Clk_in)
    begin
        reqAge <= Req ? reqAge + 1 : 0;
        if (Req)
        begin
            seenReq <= 1'b1;
        end
    end

    idleOutputsZero: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        !seenReq |-> (!Ack && TreeTable == '0 && RootRight == '0 && RootLeft == '0))
        else failRun($sformatf("error at %0t: outputs not idle before first Req", $time));

    // Load has wiped the previous tree before the first merge lands
    loadClears: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        reqAge == 2 |-> (TreeTable == '0 && RootRight == '0 && RootLeft == '0))
        else failRun($sformatf("error at %0t: outputs not cleared by Load", $time));

    ackNeedsReq: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        $rose(Ack) |-> Req)
        else failRun($sformatf("error at %0t: Ack rose with Req low", $time));

    ackStaysLow: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        (!Ack && !Req) |=> !Ack)
        else failRun($sformatf("error at %0t: Ack rose without Req", $time));

    ackHolds: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        (Ack && Req) |=> Ack)
        else failRun($sformatf("error at %0t: Ack dropped while Req high", $time));

    ackDrops: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        (Ack && !Req) |=> !Ack)
        else failRun($sformatf("error at %0t: Ack still high after Req fell", $time));

    // reqAge includes the sampling edge, Ack shows one edge after it is set
    ackLatency: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        $rose(Ack) |-> reqAge == AckLatency + 1)
        else failRun($sformatf("error at %0t: Ack after %0d edges, expected %0d",
            $time, reqAge - 1, AckLatency));

    tableMatches: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        Ack |-> TreeTable == expTable)
        else failRun($sformatf("error at %0t: TreeTable %h, expected %h",
            $time, TreeTable, expTable));

    rootMatches: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        Ack |-> (RootRight == expRight && RootLeft == expLeft))
        else failRun($sformatf("error at %0t: root %0d/%0d, expected %0d/%0d",
            $time, RootRight, RootLeft, expRight, expLeft));

    always @(posedge Clk_in)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == MaxCycles)
        begin
            failRun($sformatf("timeout: runs not finished after %0d cycles", MaxCycles));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        n_Rst       = 1'b0;
        Req         = 1'b0;
        LeafWeights = '0;
        runWeights  = '0;
        expTable    = '0;
        expRight    = '0;
        expLeft     = '0;
        repeat (ResetCycles) @(posedge Clk_in);
        n_Rst <= 1'b1;
        repeat (2) @(posedge Clk_in);           // idle outputs checked here
        makeTiedWeights();
        runTree();
        makeZeroWeights();
        runTree();
        for (int r = 0; r < RandomRuns; r++)
        begin
            makeRandomWeights();
            runTree();
        end
        repeat (2) @(posedge Clk_in);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== rtl/huffPkg.sv ====
package huffPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////////////////////////////////////////

    localparam int WeightW    = 9;                     // bit 8 only set for none
    localparam int IdxW       = 5;
    localparam int EntryW     = 3 * IdxW;              // parent, left, right
    localparam int NumLeaves  = 10;
    localparam int NumNodes   = 18;
    localparam int NumEntries = NumNodes - NumLeaves;  // one per parent
    localparam int EntryIdxW  = $clog2(NumEntries);

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [WeightW-1:0] weight_t;
    typedef logic [IdxW-1:0]    nodeIdx_t;
    typedef logic [EntryW-1:0]  treeEntry_t;

    // the root is the merge whose sum reaches the full weight
    localparam weight_t TotalWeight = weight_t'(256);

    // loses every compare against a real node
    localparam weight_t NoneWeight = weight_t'(256);

    localparam nodeIdx_t NoNode = nodeIdx_t'(31);

    typedef enum logic [2:0]
    {
        Idle,
        Load,
        PickFirst,
        PickSecond,
        Merge,
        Done
    } ctrlState_t;

endpackage

// ==== rtl/huffTreeTop.sv ====
`timescale 1ns/1ps

module huffTreeTop
(
    input  logic                                           Clk_in,
    input  logic                                           n_Rst,

    // four-phase start
    input  logic                                           Req,
    output logic                                           Ack,

    // leaf weights, stable while Req is high
    input  huffPkg::weight_t [huffPkg::NumLeaves-1:0]      LeafWeights,

    // result
    output huffPkg::treeEntry_t [huffPkg::NumEntries-1:0]  TreeTable,
    output huffPkg::nodeIdx_t                              RootRight,
    output huffPkg::nodeIdx_t                              RootLeft
);

    ////////////////////////////////////////////////////////////////////////////
    // node bus
    ////////////////////////////////////////////////////////////////////////////

    nodeIf nodes_i ();

    nodeWeightStore store_i
    (
        .Clk_in      (Clk_in),
        .n_Rst       (n_Rst),
        .nodes       (nodes_i.store),
        .LeafWeights (LeafWeights)
    );

    minFinder finder_i
    (
        .nodes (nodes_i.finder)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    mergeController ctrl_i
    (
        .Clk_in    (Clk_in),
        .n_Rst     (n_Rst),
        .nodes     (nodes_i.ctrl),
        .Req       (Req),
        .Ack       (Ack),
        .TreeTable (TreeTable),
        .RootRight (RootRight),
        .RootLeft  (RootLeft)
    );

endmodule

// ==== rtl/mergeController.sv ====
`timescale 1ns/1ps

module mergeController
(
    input  logic                                           Clk_in,
    input  logic                                           n_Rst,
    nodeIf.ctrl                                            nodes,
    input  logic                                           Req,
    output logic                                           Ack,
    output huffPkg::treeEntry_t [huffPkg::NumEntries-1:0]  TreeTable,
    output huffPkg::nodeIdx_t                              RootRight,
    output huffPkg::nodeIdx_t                              RootLeft
);
    import huffPkg::*;

    ctrlState_t state;

    nodeIdx_t parentIdx;                   // next parent slot
    nodeIdx_t firstIdx;
    nodeIdx_t secondIdx;
    weight_t  firstWeight;
    weight_t  secondWeight;
    weight_t  mergeSum;
    nodeIdx_t entryOffset;
    logic [EntryIdxW-1:0] entryIdx;
    logic     isParent;

    // pairs never exceed the total, 9 bits hold the sum
    assign mergeSum    = firstWeight + secondWeight;
    assign isParent    = (mergeSum < TotalWeight);
    assign entryOffset = parentIdx - nodeIdx_t'(NumLeaves);
    assign entryIdx    = entryOffset[EntryIdxW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // commands to the store
    ////////////////////////////////////////////////////////////////////////////

    assign nodes.Load     = (state == Load);
    assign nodes.MarkUsed = (state == PickFirst) || (state == PickSecond);
    assign nodes.WrEn     = (state == Merge) && isParent;
    assign nodes.WrIdx    = parentIdx;
    assign nodes.WrWeight = mergeSum;

    ////////////////////////////////////////////////////////////////////////////
    // round FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
        begin
            state     <= Idle;
            Ack       <= 1'b0;
            TreeTable <= '0;
            RootRight <= '0;
            RootLeft  <= '0;
            parentIdx <= nodeIdx_t'(NumLeaves);
        end
        else
        begin
            case (state)
                Idle:
                begin
                    if (Req)
                    begin
                        state <= Load;
                    end
                end
                Load:
                begin
                    // wipe the previous tree
                    TreeTable <= '0;
                    RootRight <= '0;
                    RootLeft  <= '0;
                    parentIdx <= nodeIdx_t'(NumLeaves);
                    state     <= PickFirst;
                end
                PickFirst:  state <= PickSecond;
                PickSecond: state <= Merge;
                Merge:
                begin
                    if (isParent)
                    begin
                        TreeTable[entryIdx] <= treeEntry_t'({parentIdx, secondIdx, firstIdx});
                        parentIdx           <= parentIdx + nodeIdx_t'(1);
                        state               <= PickFirst;
                    end
                    else
                    begin
                        RootRight <= firstIdx;     // root found
                        RootLeft  <= secondIdx;
                        Ack       <= 1'b1;
                        state     <= Done;
                    end
                end
                Done:
                begin
                    if (!Req)
                    begin
                        Ack   <= 1'b0;
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // pick registers
    always_ff @(posedge Clk_in)
    begin
        if (state == PickFirst)
        begin
            firstIdx    <= nodes.MinIdx;
            firstWeight <= nodes.MinWeight;
        end
        else if (state == PickSecond)
        begin
            secondIdx    <= nodes.MinIdx;
            secondWeight <= nodes.MinWeight;
        end
    end

    ackOnlyAfterRun: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        state == Idle |-> !Ack)
        else $error("Ack high in Idle");

    // the store must still hold an open node whenever a pick is made
    pickFindsNode: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        (state == PickFirst || state == PickSecond) |-> nodes.MinIdx != NoNode)
        else $error("pick found no open node");

    parentInRange: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        (state == Merge && isParent) |-> parentIdx <= nodeIdx_t'(NumNodes - 1))
        else $error("parent counter past last node");

endmodule

// ==== rtl/minFinder.sv ====
`timescale 1ns/1ps

module minFinder
(
    nodeIf.finder nodes
);
    import huffPkg::*;

    weight_t  bestWeight;
    nodeIdx_t bestIdx;

    // linear scan from node 0 up
    // strict compare keeps the lower index on a tie
    always_comb
    begin
        bestWeight = NoneWeight;
        bestIdx    = NoNode;               // stays here if all nodes used
        for (int i = 0; i < NumNodes; i++)
        begin
            if (nodes.Weights[i] < bestWeight)
            begin
                bestWeight = nodes.Weights[i];
                bestIdx    = nodeIdx_t'(i);
            end
        end
    end

    assign nodes.MinWeight = bestWeight;
    assign nodes.MinIdx    = bestIdx;

endmodule

// ==== rtl/nodeIf.sv ====
`timescale 1ns/1ps

interface nodeIf;
    import huffPkg::*;

    // store -> finder
    weight_t [NumNodes-1:0] Weights;   // used nodes read as NoneWeight

    // finder -> store, ctrl
    nodeIdx_t MinIdx;
    weight_t  MinWeight;

    // ctrl commands
    logic     Load;
    logic     MarkUsed;                // marks the node at MinIdx
    logic     WrEn;
    nodeIdx_t WrIdx;
    weight_t  WrWeight;

    modport store
    (
        input  Load, MarkUsed, MinIdx, WrEn, WrIdx, WrWeight,
        output Weights
    );

    modport finder
    (
        input  Weights,
        output MinIdx, MinWeight
    );

    modport ctrl
    (
        input  MinIdx, MinWeight,
        output Load, MarkUsed, WrEn, WrIdx, WrWeight
    );

endinterface

// ==== rtl/nodeWeightStore.sv ====
`timescale 1ns/1ps

module nodeWeightStore
(
    input  logic                                       Clk_in,
    input  logic                                       n_Rst,
    nodeIf.store                                       nodes,
    input  huffPkg::weight_t [huffPkg::NumLeaves-1:0]  LeafWeights
);
    import huffPkg::*;

    weight_t             nodeWeight [NumNodes];
    logic [NumNodes-1:0] nodeUsed;

    ////////////////////////////////////////////////////////////////////////////
    // used flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
        begin
            nodeUsed <= '1;                    // everything reads as none
        end
        else if (nodes.Load)
        begin
            // leaves open, parents not built yet
            nodeUsed <= {{(NumNodes - NumLeaves){1'b1}}, {NumLeaves{1'b0}}};
        end
        else
        begin
            if (nodes.MarkUsed)
            begin
                nodeUsed[nodes.MinIdx] <= 1'b1;
            end
            if (nodes.WrEn)
            begin
                nodeUsed[nodes.WrIdx] <= 1'b0; // new parent joins the pool
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // weights
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_in)
    begin
        if (nodes.Load)
        begin
            for (int i = 0; i < NumLeaves; i++)
            begin
                nodeWeight[i] <= LeafWeights[i];
            end
        end
        else if (nodes.WrEn)
        begin
            nodeWeight[nodes.WrIdx] <= nodes.WrWeight;
        end
    end

    always_comb
    begin
        for (int i = 0; i < NumNodes; i++)
        begin
            nodes.Weights[i] = nodeUsed[i] ? NoneWeight : nodeWeight[i];
        end
    end

    // parents only ever land above the leaves
    parentSlotOnly: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        nodes.WrEn |-> nodes.WrIdx inside {[NumLeaves:NumNodes-1]})
        else $error("parent write to index %0d", nodes.WrIdx);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the Huffman tree testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module huffTreeTb -Mdir obj_dir -o simv

# the log decides the result, so a failing run must not stop the script here
status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log
echo "simulator exit status: $status"

if grep -qx "Regression passed" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation FAILED"
    exit 1
fi

// ==== tb.f ====
rtl/huffPkg.sv
rtl/nodeIf.sv
rtl/nodeWeightStore.sv
rtl/minFinder.sv
rtl/mergeController.sv
rtl/huffTreeTop.sv
dv/huffTreeTb.sv
